/* logic/irq_pkg.sv */
// Shared types and constants of the interrupt controller
// Covers the interrupt vectors, cause encoding, WFI decode and sleep FSM states
package irq_pkg;

  // ------------------------------
  // Vector and word types
  // ------------------------------

  // One bit per interrupt number, used for requests, mip and mie
  typedef logic [31:0] irq_vec_t;

  // Interrupt number as carried on the acknowledge
  typedef logic [4:0] irq_id_t;

  // Interrupt flag in the top bit, id below it
  typedef logic [5:0] mcause_t;

  // Retired instruction word
  typedef logic [31:0] instr_t;

  // ------------------------------
  // Interrupt map
  // ------------------------------

  // Software 3, timer 7, external 11 and the platform lines 16 to 31
  localparam irq_vec_t IRQ_VALID_MASK = 32'hffff_0888;

  // ------------------------------
  // WFI and sleep
  // ------------------------------

  // Full 32-bit encoding of WFI, no don't-care fields
  localparam instr_t WFI_ENCODING = 32'h1050_0073;

  // Cycles spent in DRAIN before the core is reported asleep
  localparam int unsigned SLEEP_DRAIN_CYCLES = 6;

  // Drain counter wide enough to count up to SLEEP_DRAIN_CYCLES - 1
  localparam int unsigned DRAIN_CNT_W = $clog2(SLEEP_DRAIN_CYCLES);
  typedef logic [DRAIN_CNT_W-1:0] drain_cnt_t;

  // Sleep controller states
  typedef enum logic [1:0] {
    AWAKE,
    DRAIN,
    ASLEEP
  } sleep_state_e;

endpackage

/* logic/irq_pending.sv */
// Pending register (mip) sampled from the external request lines
// Reserved interrupt numbers are always read as zero
`timescale 1ns/1ns

module irq_pending (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Level requests from the platform
  input  irq_pkg::irq_vec_t irq_i,

  // Masked pending bits, one cycle behind irq_i
  output irq_pkg::irq_vec_t mip_o
);

  import irq_pkg::*;

  // ------------------------------
  // Pending register
  // ------------------------------

  irq_vec_t mip_q;

  // Requests are levels, so the register simply follows the lines
  // Only bits 3, 7, 11 and 16..31 can ever be set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & IRQ_VALID_MASK;
    end
  end

  // Shared by the arbiter, the sleep controller and the top-level port
  assign mip_o = mip_q;

endmodule

/* logic/irq_csr.sv */
// Machine-mode interrupt CSRs: mie, mstatus.mie with its saved copy, and mcause
// Updated by software writes, trap entry on acknowledge and trap return
`timescale 1ns/1ns

module irq_csr (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Software write to mie
  input  logic              mie_we_i,
  input  irq_pkg::irq_vec_t mie_wdata_i,

  // Software write to the global enable
  input  logic              mstatus_mie_we_i,
  input  logic              mstatus_mie_wdata_i,

  // Trap return strobe
  input  logic              mret_i,

  // Trap entry from the arbiter
  input  logic              irq_ack_i,
  input  irq_pkg::irq_id_t  irq_id_i,

  output irq_pkg::irq_vec_t mie_o,
  output logic              mstatus_mie_o,
  output irq_pkg::mcause_t  mcause_o
);

  import irq_pkg::*;

  irq_vec_t mie_q;
  logic     mstatus_mie_q;
  // Saved copy of the global enable (mstatus.mpie)
  logic     mstatus_mpie_q;
  mcause_t  mcause_q;

  // ------------------------------
  // Local enables
  // ------------------------------

  // Reserved enables are dropped on write so they always read as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (mie_we_i) begin
      mie_q <= mie_wdata_i & IRQ_VALID_MASK;
    end
  end

  // ------------------------------
  // Global enable and trap state
  // ------------------------------

  // Priority: acknowledge, then return, then software write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mcause_q       <= '0;
    end else if (irq_ack_i) begin
      // Trap entry, interrupts globally off until the handler returns
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
      mcause_q       <= {1'b1, irq_id_i};
    end else if (mret_i) begin
      // Restore the enable; saved copy goes back to 1 as on a real mret
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (mstatus_mie_we_i) begin
      mstatus_mie_q  <= mstatus_mie_wdata_i;
    end
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mcause_o      = mcause_q;

endmodule

/* logic/irq_arbiter.sv */
// Fixed-priority interrupt arbiter with a registered acknowledge pulse
// Order is 31 down to 16, then 11, then 3, then 7
`timescale 1ns/1ns

module irq_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Pending and enable state from the sampler and CSR file
  input  irq_pkg::irq_vec_t mip_i,
  input  irq_pkg::irq_vec_t mie_i,
  input  logic              mstatus_mie_i,

  // One-cycle acknowledge with the winning id
  output logic              irq_ack_o,
  output irq_pkg::irq_id_t  irq_id_o
);

  import irq_pkg::*;

  irq_vec_t pend_en;
  logic     sel_valid;
  irq_id_t  sel_id;
  logic     take;

  logic     irq_ack_q;
  irq_id_t  irq_id_q;

  // Only requests that are both pending and locally enabled compete
  assign pend_en = mip_i & mie_i;

  // ------------------------------
  // Priority select
  // ------------------------------

  // Lowest priority is checked first so higher ones overwrite it
  always_comb begin
    sel_valid = 1'b0;
    sel_id    = '0;
    if (pend_en[7]) begin
      sel_valid = 1'b1;
      sel_id    = irq_id_t'(7);
    end
    if (pend_en[3]) begin
      sel_valid = 1'b1;
      sel_id    = irq_id_t'(3);
    end
    if (pend_en[11]) begin
      sel_valid = 1'b1;
      sel_id    = irq_id_t'(11);
    end
    // Platform lines, 31 ends up on top
    for (int i = 16; i < 32; i++) begin
      if (pend_en[i]) begin
        sel_valid = 1'b1;
        sel_id    = irq_id_t'(i);
      end
    end
  end

  // Global enable still reads 1 during the ack cycle, so the previous
  // ack blocks a back-to-back request until trap entry lands
  assign take = sel_valid && mstatus_mie_i && !irq_ack_q;

  // ------------------------------
  // Acknowledge register
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_q <= 1'b0;
    end else begin
      irq_ack_q <= take;
    end
  end

  // Id only meaningful while the ack is high
  always_ff @(posedge clk_i) begin
    if (take) begin
      irq_id_q <= sel_id;
    end
  end

  assign irq_ack_o = irq_ack_q;
  assign irq_id_o  = irq_id_q;

endmodule

/* logic/wfi_sleep.sv */
// WFI detector and sleep FSM with a fixed drain period
// Wakes on any pending, locally enabled request or on a debug request
`timescale 1ns/1ns

module wfi_sleep (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Retire port
  input  logic              instr_valid_i,
  input  irq_pkg::instr_t   instr_i,

  // Wake sources
  input  irq_pkg::irq_vec_t mip_i,
  input  irq_pkg::irq_vec_t mie_i,
  input  logic              debug_req_i,

  output logic              core_sleep_o
);

  import irq_pkg::*;

  sleep_state_e state_q, state_d;
  drain_cnt_t   cnt_q, cnt_d;
  logic         core_sleep_q;

  logic wfi_retired;
  logic wake;

  // Exact match, WFI has no operand fields
  assign wfi_retired = instr_valid_i && (instr_i == WFI_ENCODING);

  // Global enable plays no part here, as WFI wakes on local enables only
  assign wake = (|(mip_i & mie_i)) || debug_req_i;

  // ------------------------------
  // Next state
  // ------------------------------

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      AWAKE: begin
        // A WFI with a wake source already present retires as a nop
        if (wfi_retired && !wake) begin
          state_d = DRAIN;
          cnt_d   = '0;
        end
      end
      DRAIN: begin
        if (wake) begin
          state_d = AWAKE;
        end else if (cnt_q == drain_cnt_t'(SLEEP_DRAIN_CYCLES - 1)) begin
          state_d = ASLEEP;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      ASLEEP: begin
        if (wake) begin
          state_d = AWAKE;
        end
      end
      default: state_d = AWAKE;
    endcase
  end

  // ------------------------------
  // State registers
  // ------------------------------

  // Sleep flag follows the next state so it rises and falls with ASLEEP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= AWAKE;
      cnt_q        <= '0;
      core_sleep_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      cnt_q        <= cnt_d;
      core_sleep_q <= (state_d == ASLEEP);
    end
  end

  assign core_sleep_o = core_sleep_q;

endmodule

/* logic/irq_ctrl_top.sv */
// Top level of the machine-mode interrupt controller
// Connects the pending sampler, CSR file, arbiter and sleep controller
`timescale 1ns/1ns

module irq_ctrl_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // External requests
  input  irq_pkg::irq_vec_t irq_i,

  // CSR write strobes
  input  logic              mie_we_i,
  input  irq_pkg::irq_vec_t mie_wdata_i,
  input  logic              mstatus_mie_we_i,
  input  logic              mstatus_mie_wdata_i,
  input  logic              mret_i,

  // Retired instructions and debug
  input  logic              instr_valid_i,
  input  irq_pkg::instr_t   instr_i,
  input  logic              debug_req_i,

  // Acknowledge and CSR state
  output logic              irq_ack_o,
  output irq_pkg::irq_id_t  irq_id_o,
  output irq_pkg::irq_vec_t mip_o,
  output irq_pkg::irq_vec_t mie_o,
  output logic              mstatus_mie_o,
  output irq_pkg::mcause_t  mcause_o,

  output logic              core_sleep_o
);

  import irq_pkg::*;

  irq_vec_t mip;
  irq_vec_t mie;
  logic     mstatus_mie;
  mcause_t  mcause;
  logic     irq_ack;
  irq_id_t  irq_id;

  // ------------------------------
  // Producer and CSR file
  // ------------------------------

  irq_pending i_irq_pending (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .irq_i  (irq_i),
    .mip_o  (mip)
  );

  // Acknowledge doubles as the trap-entry strobe
  irq_csr i_irq_csr (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .mie_we_i            (mie_we_i),
    .mie_wdata_i         (mie_wdata_i),
    .mstatus_mie_we_i    (mstatus_mie_we_i),
    .mstatus_mie_wdata_i (mstatus_mie_wdata_i),
    .mret_i              (mret_i),
    .irq_ack_i           (irq_ack),
    .irq_id_i            (irq_id),
    .mie_o               (mie),
    .mstatus_mie_o       (mstatus_mie),
    .mcause_o            (mcause)
  );

  // ------------------------------
  // Consumers
  // ------------------------------

  irq_arbiter i_irq_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mip_i         (mip),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .irq_ack_o     (irq_ack),
    .irq_id_o      (irq_id)
  );

  wfi_sleep i_wfi_sleep (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .mip_i         (mip),
    .mie_i         (mie),
    .debug_req_i   (debug_req_i),
    .core_sleep_o  (core_sleep_o)
  );

  assign irq_ack_o     = irq_ack;
  assign irq_id_o      = irq_id;
  assign mip_o         = mip;
  assign mie_o         = mie;
  assign mstatus_mie_o = mstatus_mie;
  assign mcause_o      = mcause;

endmodule

/* bench/irq_monitor.sv */
// Passive checker on the interrupt controller ports
// Ack pulse width, legality of the ack id and mip sampling
`timescale 1ns/1ns

module irq_monitor (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_pkg::irq_vec_t irq_i,
  input  logic              irq_ack_i,
  input  irq_pkg::irq_id_t  irq_id_i,
  input  irq_pkg::irq_vec_t mip_i,
  input  irq_pkg::irq_vec_t mie_i,
  output logic              error_o
);

  import irq_pkg::*;

  // Bits 3, 7, 11 and 16 to 31
  localparam irq_vec_t VALID_BITS = 32'hffff_0888;

  irq_vec_t irq_q   = '0;
  irq_vec_t mip_q   = '0;
  irq_vec_t mie_q   = '0;
  logic     ack_q   = 1'b0;
  logic     sampled = 1'b0;

  initial error_o = 1'b0;

  // Requests move on the falling edge, the rising edge sees them settled
  always @(posedge clk_i) begin
    irq_q   <= irq_i;
    sampled <= rst_ni;
  end

  // All outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni && sampled) begin
      assert (mip_i === (irq_q & VALID_BITS)) else begin
        $display("ERR %0t mip_o got %h expected %h", $time, mip_i, irq_q & VALID_BITS);
        error_o = 1'b1;
      end
      // Ack is a single-cycle pulse
      assert (!(irq_ack_i && ack_q)) else begin
        $display("ERR %0t irq_ack_o got 1 expected 0", $time);
        error_o = 1'b1;
      end
      // Winner must have been pending and enabled in the cycle before
      assert (!irq_ack_i ||
              (VALID_BITS[irq_id_i] && mip_q[irq_id_i] && mie_q[irq_id_i])) else begin
        $display("ERR %0t irq_id_o got %0d expected one of %h",
                 $time, irq_id_i, mip_q & mie_q);
        error_o = 1'b1;
      end
    end
    ack_q <= irq_ack_i && rst_ni;
    mip_q <= mip_i;
    mie_q <= mie_i;
  end

endmodule

/* bench/irq_ctrl_tb.sv */
// Testbench of the interrupt controller with clock, reset, DUT and monitor
// Directed tests for sampling, priority, masking, trap entry and WFI sleep
`timescale 1ns/1ns

module irq_ctrl_tb;

  import irq_pkg::*;

  localparam irq_vec_t VALID_BITS   = 32'hffff_0888;
  localparam instr_t   WFI_WORD     = 32'h1050_0073;
  localparam int       DRAIN_CYCLES = 6;
  localparam int       TIMEOUT      = 40;

  logic     clk_i, rst_ni, mie_we_i, mstatus_mie_we_i, mstatus_mie_wdata_i, mret_i;
  logic     instr_valid_i, debug_req_i, irq_ack_o, mstatus_mie_o, core_sleep_o;
  logic     mon_error;
  irq_vec_t irq_i, mie_wdata_i, mip_o, mie_o;
  irq_id_t  irq_id_o;
  mcause_t  mcause_o;
  instr_t   instr_i;

  irq_ctrl_top i_irq_ctrl_top (.*);

  irq_monitor i_irq_monitor (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .irq_ack_i (irq_ack_o),
    .irq_id_i  (irq_id_o),
    .mip_i     (mip_o),
    .mie_i     (mie_o),
    .error_o   (mon_error)
  );

  // Starts high so time zero brings no falling edge
  initial begin
    clk_i = 1'b1;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic fail_stop();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(posedge mon_error) begin
    fail_stop();
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic tick(int n = 1);
    repeat (n) @(negedge clk_i);
  endtask

  // Order 31 down to 16, then 11, 3, 7
  function automatic int winner(irq_vec_t pend);
    int id;
    for (int k = 0; k < 19; k++) begin
      id = (k < 16) ? 31 - k : (k == 16) ? 11 : (k == 17) ? 3 : 7;
      if (pend[id]) begin
        return id;
      end
    end
    return -1;
  endfunction

  task automatic write_mie(irq_vec_t val);
    mie_we_i    = 1'b1;
    mie_wdata_i = val;
    tick();
    mie_we_i    = 1'b0;
  endtask

  task automatic write_gie(logic val);
    mstatus_mie_we_i    = 1'b1;
    mstatus_mie_wdata_i = val;
    tick();
    mstatus_mie_we_i    = 1'b0;
  endtask

  task automatic return_from_trap();
    mret_i = 1'b1;
    tick();
    mret_i = 1'b0;
  endtask

  task automatic retire(instr_t word);
    instr_valid_i = 1'b1;
    instr_i       = word;
    tick();
    instr_valid_i = 1'b0;
  endtask

  task automatic no_ack(int n);
    repeat (n) begin
      tick();
      check_value("irq_ack_o", irq_ack_o, 0);
    end
  endtask

  task automatic wait_ack(output int id);
    int n;
    n = 0;
    while (!irq_ack_o && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (!irq_ack_o) begin
      $display("Timeout while waiting for an interrupt acknowledge");
      fail_stop();
    end
    id = irq_id_o;
  endtask

  task automatic wait_sleep(logic level);
    int n;
    n = 0;
    while (core_sleep_o !== level && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (core_sleep_o !== level) begin
      $display("Timeout while waiting for core_sleep_o to become %0b", level);
      fail_stop();
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic sample_pending();
    irq_vec_t pat;
    repeat (20) begin
      pat   = $urandom;
      irq_i = pat;
      tick();
      check_value("mip_o", mip_o, pat & VALID_BITS);
    end
    irq_i = '0;
    tick();
  endtask

  task automatic priority_order();
    irq_vec_t pat;
    write_mie('1);
    check_value("mie_o", mie_o, VALID_BITS);
    write_gie(1'b1);
    for (int k = 0; k < 8; k++) begin
      if (k % 2 == 0) begin
        // Line 7 is lowest, so adding it never hides the true winner
        pat = ($urandom & VALID_BITS) | (32'h1 << 7);
      end else begin
        // No platform lines, so 11, 3 and 7 decide among themselves
        pat = (32'h1 << 7) |
              ((k & 2) ? (32'h1 << 3) : 32'h0) |
              ((k & 4) ? (32'h1 << 11) : 32'h0);
      end
      irq_i = pat;
      tick();
      check_value("irq_ack_o", irq_ack_o, 0);
      tick();
      check_value("irq_ack_o", irq_ack_o, 1);
      check_value("irq_id_o", irq_id_o, winner(pat));
      irq_i = '0;
      tick();
      check_value("mcause_o", mcause_o, {1'b1, 5'(winner(pat))});
      return_from_trap();
      tick();
    end
  endtask

  task automatic masking();
    int id;
    write_mie(VALID_BITS & ~(32'h1 << 20));
    irq_i = 32'h1 << 20;
    no_ack(12);
    write_mie(VALID_BITS);
    wait_ack(id);
    check_value("irq_id_o", id, 20);
    irq_i = '0;
    tick();
    return_from_trap();
    // Locally enabled but globally off
    write_gie(1'b0);
    irq_i = 32'h1 << 11;
    no_ack(12);
    write_gie(1'b1);
    wait_ack(id);
    check_value("irq_id_o", id, 11);
    irq_i = '0;
    tick();
    return_from_trap();
  endtask

  task automatic trap_entry_return();
    int id;
    irq_i = (32'h1 << 3) | (32'h1 << 16);
    wait_ack(id);
    check_value("irq_id_o", id, 16);
    tick();
    check_value("mstatus_mie_o", mstatus_mie_o, 0);
    check_value("mcause_o", mcause_o, {1'b1, 5'd16});
    // Requests stay up while the handler runs with interrupts off
    no_ack(10);
    return_from_trap();
    check_value("mstatus_mie_o", mstatus_mie_o, 1);
    wait_ack(id);
    check_value("irq_id_o", id, 16);
    irq_i = '0;
    tick();
    return_from_trap();
  endtask

  task automatic wfi_sleep_entry();
    retire(32'h0000_0013);
    no_ack(DRAIN_CYCLES + 2);
    check_value("core_sleep_o", core_sleep_o, 0);
    retire(WFI_WORD);
    // One cycle already spent inside retire
    repeat (DRAIN_CYCLES) begin
      check_value("core_sleep_o", core_sleep_o, 0);
      tick();
    end
    check_value("core_sleep_o", core_sleep_o, 1);
  endtask

  task automatic wfi_wake();
    write_gie(1'b0);
    write_mie(VALID_BITS & ~(32'h1 << 7));
    // Disabled line keeps the core asleep
    irq_i = 32'h1 << 7;
    repeat (10) begin
      tick();
      check_value("core_sleep_o", core_sleep_o, 1);
    end
    irq_i = 32'h1 << 25;
    wait_sleep(1'b0);
    irq_i = '0;
    tick(2);
    retire(WFI_WORD);
    wait_sleep(1'b1);
    debug_req_i = 1'b1;
    wait_sleep(1'b0);
    debug_req_i = 1'b0;
    tick();
  endtask

  initial begin
    void'($urandom(32'ha26a42f4));
    rst_ni              = 1'b0;
    irq_i               = '0;
    mie_we_i            = 1'b0;
    mie_wdata_i         = '0;
    mstatus_mie_we_i    = 1'b0;
    mstatus_mie_wdata_i = 1'b0;
    mret_i              = 1'b0;
    instr_valid_i       = 1'b0;
    instr_i             = '0;
    debug_req_i         = 1'b0;
    tick(8);
    rst_ni = 1'b1;
    check_value("irq_ack_o", irq_ack_o, 0);
    check_value("core_sleep_o", core_sleep_o, 0);
    check_value("mip_o", mip_o, 0);
    check_value("mie_o", mie_o, 0);
    check_value("mstatus_mie_o", mstatus_mie_o, 0);
    check_value("mcause_o", mcause_o, 0);
    sample_pending();
    priority_order();
    masking();
    trap_entry_return();
    wfi_sleep_entry();
    wfi_wake();
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* compile.f */
logic/irq_pkg.sv
logic/irq_pending.sv
logic/irq_csr.sv
logic/irq_arbiter.sv
logic/wfi_sleep.sv
logic/irq_ctrl_top.sv
bench/irq_monitor.sv
bench/irq_ctrl_tb.sv
